// File: Makefile
TOP := key_extract_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: source/config_writer.sv
// control stream filter that turns table-write packets into entry writes and forwards the rest
`default_nettype none

module config_writer #(
    parameter int unsigned STAGE_ID  = 0,
    parameter int unsigned KEY_EX_ID = 1
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire ctrl_pkg::ctrl_data_t  c_s_axis_tdata,
    input  wire                        c_s_axis_tvalid,
    input  wire                        c_s_axis_tlast,
    output ctrl_pkg::ctrl_data_t       c_m_axis_tdata,
    output logic                       c_m_axis_tvalid,
    output logic                       c_m_axis_tlast,
    output logic                       off_wr_en,
    output logic                       mask_wr_en,
    output ctrl_pkg::tbl_addr_t        wr_idx,
    output ctrl_pkg::key_off_t         off_wr_data,
    output ctrl_pkg::key_mask_t        mask_wr_data
);

    typedef enum logic [1:0] {
        CW_IDLE,
        CW_WR_OFF,
        CW_WR_MASK
    } cw_state_t;

    cw_state_t            state;
    ctrl_pkg::ctrl_data_t swapped;
    ctrl_pkg::tbl_addr_t  next_idx;
    logic [7:0]           mod_id;
    logic                 hit;
    logic                 data_beat;

    // upper 5 bits stage, lower 3 bits extractor id
    assign mod_id = c_s_axis_tdata[ctrl_pkg::MOD_ID_LSB +: 8];

    assign hit = c_s_axis_tvalid
        && c_s_axis_tdata[ctrl_pkg::TAG_LSB +: 16] == ctrl_pkg::CTRL_FLAG
        && mod_id[7:3] == 5'(STAGE_ID)
        && mod_id[2:0] == 3'(KEY_EX_ID);

    assign data_beat = c_s_axis_tvalid && state != CW_IDLE;

    // beats arrive little endian, entries sit at the top of the swapped beat
    always_comb begin
        for (int i = 0; i < ctrl_pkg::CTRL_W / 8; i++) begin
            swapped[8*i +: 8] = c_s_axis_tdata[ctrl_pkg::CTRL_W - 1 - 8*i -: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= CW_IDLE;
            c_m_axis_tvalid <= 1'b0;
            c_m_axis_tlast  <= 1'b0;
            off_wr_en       <= 1'b0;
            mask_wr_en      <= 1'b0;
        end else begin
            c_m_axis_tvalid <= 1'b0;
            off_wr_en       <= 1'b0;
            mask_wr_en      <= 1'b0;
            case (state)
                CW_IDLE: begin
                    if (!hit) begin
                        c_m_axis_tvalid <= c_s_axis_tvalid;
                        c_m_axis_tlast  <= c_s_axis_tlast;
                    end else if (!c_s_axis_tlast) begin
                        // zero select picks the offset table
                        state <= (c_s_axis_tdata[ctrl_pkg::TBL_SEL_LSB +: 4] == 4'd0) ?
                                 CW_WR_OFF : CW_WR_MASK;
                    end
                end
                CW_WR_OFF, CW_WR_MASK: begin
                    if (c_s_axis_tvalid) begin
                        off_wr_en  <= (state == CW_WR_OFF);
                        mask_wr_en <= (state == CW_WR_MASK);
                        if (c_s_axis_tlast) begin
                            state <= CW_IDLE;
                        end
                    end
                end
                default: state <= CW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CW_IDLE && !hit) begin
            c_m_axis_tdata <= c_s_axis_tdata;
        end else if (state == CW_IDLE) begin
            next_idx <= c_s_axis_tdata[ctrl_pkg::START_IDX_LSB +: $bits(ctrl_pkg::tbl_addr_t)];
        end
        // each data beat takes the next consecutive entry
        if (data_beat) begin
            wr_idx       <= next_idx;
            next_idx     <= next_idx + 1'b1;
            off_wr_data  <= swapped[ctrl_pkg::CTRL_W - 1 -: $bits(ctrl_pkg::key_off_t)];
            mask_wr_data <= swapped[ctrl_pkg::CTRL_W - 1 -: $bits(ctrl_pkg::key_mask_t)];
        end
    end

    a_one_table: assert property (@(posedge clk) disable iff (!rst_n)
        !(off_wr_en && mask_wr_en));

endmodule

`default_nettype wire

// File: source/ctrl_pkg.sv
// control stream beat layout and table entry types used by the config writer and the tables
`default_nettype none

package ctrl_pkg;

    localparam int CTRL_W    = 512;
    localparam int TBL_DEPTH = 16;

    localparam logic [15:0] CTRL_FLAG = 16'hf2f1;

    // field positions in the first beat of a control packet
    localparam int TAG_LSB       = 320;
    localparam int MOD_ID_LSB    = 368;
    localparam int TBL_SEL_LSB   = 376;
    localparam int START_IDX_LSB = 384;

    typedef logic [CTRL_W-1:0]            ctrl_data_t;
    typedef logic [$clog2(TBL_DEPTH)-1:0] tbl_addr_t;

    // container selectors in key slot order
    typedef struct packed {
        logic [2:0] s6_0;
        logic [2:0] s6_1;
        logic [2:0] s4_0;
        logic [2:0] s4_1;
        logic [2:0] s2_0;
        logic [2:0] s2_1;
    } key_off_t;

    typedef logic [$bits(phv_pkg::key_t)-1:0] key_mask_t;

endpackage

`default_nettype wire

// File: source/key_extract_engine.sv
// captures one PHV at a time, splits it into containers and emits the masked lookup key
`default_nettype none

module key_extract_engine #(
    parameter int unsigned STAGE_ID = 0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire phv_pkg::phv_t        phv_in,
    input  wire                       phv_valid_in,
    input  wire                       ready_in,
    input  wire ctrl_pkg::key_off_t   key_off,
    input  wire ctrl_pkg::key_mask_t  key_mask,
    input  wire                       pred_bit,
    output logic                      ready_out,
    output phv_pkg::phv_t             phv_out,
    output logic                      phv_valid_out,
    output phv_pkg::key_t             key_out_masked,
    output logic                      key_valid_out,
    output phv_pkg::key_t             key_mask_out,
    output ctrl_pkg::tbl_addr_t       rd_idx,
    output phv_pkg::cont6_t           cont6 [phv_pkg::NUM_CONT],
    output phv_pkg::cont4_t           cont4 [phv_pkg::NUM_CONT],
    output phv_pkg::cont2_t           cont2 [phv_pkg::NUM_CONT],
    output phv_pkg::pred_op_t         pred_op,
    output logic                      op_load
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_OPERAND,
        ST_LOOKUP,
        ST_EMIT,
        ST_HOLD
    } state_t;

    state_t              state;
    phv_pkg::phv_t       phv_r;
    ctrl_pkg::key_off_t  off_r;
    ctrl_pkg::key_mask_t mask_r;
    phv_pkg::key_t       key_w;
    logic [phv_pkg::NUM_PRED-1:0] pred_field;
    logic                accept;
    logic                fire;

    // tables see the incoming tenant so the entry is ready one edge after acceptance
    assign rd_idx  = phv_in[phv_pkg::TENANT_LSB +: phv_pkg::TENANT_W];
    assign accept  = phv_valid_in && ready_out;
    assign fire    = (state == ST_EMIT || state == ST_HOLD) && ready_in;
    assign op_load = (state == ST_OPERAND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            ready_out     <= 1'b1;
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
        end else begin
            phv_valid_out <= 1'b0;
            key_valid_out <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        ready_out <= 1'b0;
                        state     <= ST_OPERAND;
                    end
                end
                ST_OPERAND: state <= ST_LOOKUP;
                ST_LOOKUP:  state <= ST_EMIT;
                ST_EMIT, ST_HOLD: begin
                    if (ready_in) begin
                        phv_valid_out <= 1'b1;
                        key_valid_out <= 1'b1;
                        ready_out     <= 1'b1;
                        state         <= ST_IDLE;
                    end else begin
                        state <= ST_HOLD;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            phv_r   <= phv_in;
            pred_op <= phv_in[phv_pkg::PRED_MSB - STAGE_ID * phv_pkg::PRED_W -: phv_pkg::PRED_W];
            for (int i = 0; i < phv_pkg::NUM_CONT; i++) begin
                cont6[i] <= phv_in[phv_pkg::CONT6_MSB - (phv_pkg::NUM_CONT - 1 - i) * 48 -: 48];
                cont4[i] <= phv_in[phv_pkg::CONT4_MSB - (phv_pkg::NUM_CONT - 1 - i) * 32 -: 32];
                cont2[i] <= phv_in[phv_pkg::CONT2_MSB - (phv_pkg::NUM_CONT - 1 - i) * 16 -: 16];
            end
        end
        // table outputs hold the entry read on the accepting edge
        if (state == ST_OPERAND) begin
            off_r  <= key_off;
            mask_r <= key_mask;
        end
        // outputs only change on the pulse edge
        if (fire) begin
            phv_out        <= phv_r;
            key_out_masked <= key_w & ~mask_r;
            key_mask_out   <= mask_r;
        end
    end

    // only this stage's predicate bit is set
    always_comb begin
        pred_field = '0;
        pred_field[phv_pkg::NUM_PRED - 1 - STAGE_ID] = pred_bit;
        key_w = {cont6[off_r.s6_0], cont6[off_r.s6_1],
                 cont4[off_r.s4_0], cont4[off_r.s4_1],
                 cont2[off_r.s2_0], cont2[off_r.s2_1],
                 pred_field};
    end

    // a result is handed over only while the next stage is ready
    a_valid_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (phv_valid_out || key_valid_out) |-> ready_in);

endmodule

`default_nettype wire

// File: source/key_extract_top.sv
// key extractor of one match-action stage, with its per-tenant tables and config path
`default_nettype none

module key_extract_top #(
    parameter int unsigned STAGE_ID  = 0,
    parameter int unsigned KEY_EX_ID = 1
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire phv_pkg::phv_t        phv_in,
    input  wire                       phv_valid_in,
    input  wire                       ready_in,
    input  wire ctrl_pkg::ctrl_data_t c_s_axis_tdata,
    input  wire                       c_s_axis_tvalid,
    input  wire                       c_s_axis_tlast,
    output logic                      ready_out,
    output phv_pkg::phv_t             phv_out,
    output logic                      phv_valid_out,
    output phv_pkg::key_t             key_out_masked,
    output logic                      key_valid_out,
    output phv_pkg::key_t             key_mask_out,
    output ctrl_pkg::ctrl_data_t      c_m_axis_tdata,
    output logic                      c_m_axis_tvalid,
    output logic                      c_m_axis_tlast
);

    ctrl_pkg::tbl_addr_t rd_idx;
    ctrl_pkg::tbl_addr_t wr_idx;
    ctrl_pkg::key_off_t  off_rd_data;
    ctrl_pkg::key_off_t  off_wr_data;
    ctrl_pkg::key_mask_t mask_rd_data;
    ctrl_pkg::key_mask_t mask_wr_data;
    logic                off_wr_en;
    logic                mask_wr_en;
    phv_pkg::cont6_t     cont6 [phv_pkg::NUM_CONT];
    phv_pkg::cont4_t     cont4 [phv_pkg::NUM_CONT];
    phv_pkg::cont2_t     cont2 [phv_pkg::NUM_CONT];
    phv_pkg::pred_op_t   pred_op;
    logic                op_load;
    logic                pred_bit;

    key_extract_engine #(
        .STAGE_ID (STAGE_ID)
    ) u_engine (
        .clk            (clk),
        .rst_n          (rst_n),
        .phv_in         (phv_in),
        .phv_valid_in   (phv_valid_in),
        .ready_in       (ready_in),
        .key_off        (off_rd_data),
        .key_mask       (mask_rd_data),
        .pred_bit       (pred_bit),
        .ready_out      (ready_out),
        .phv_out        (phv_out),
        .phv_valid_out  (phv_valid_out),
        .key_out_masked (key_out_masked),
        .key_valid_out  (key_valid_out),
        .key_mask_out   (key_mask_out),
        .rd_idx         (rd_idx),
        .cont6          (cont6),
        .cont4          (cont4),
        .cont2          (cont2),
        .pred_op        (pred_op),
        .op_load        (op_load)
    );

    predicate_unit u_pred (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_load  (op_load),
        .pred_op  (pred_op),
        .cont6    (cont6),
        .cont4    (cont4),
        .cont2    (cont2),
        .pred_bit (pred_bit)
    );

    key_table_ram #(
        .entry_t (ctrl_pkg::key_off_t)
    ) offset_table (
        .clk     (clk),
        .wr_en   (off_wr_en),
        .wr_idx  (wr_idx),
        .wr_data (off_wr_data),
        .rd_idx  (rd_idx),
        .rd_data (off_rd_data)
    );

    key_table_ram #(
        .entry_t (ctrl_pkg::key_mask_t)
    ) mask_table (
        .clk     (clk),
        .wr_en   (mask_wr_en),
        .wr_idx  (wr_idx),
        .wr_data (mask_wr_data),
        .rd_idx  (rd_idx),
        .rd_data (mask_rd_data)
    );

    config_writer #(
        .STAGE_ID  (STAGE_ID),
        .KEY_EX_ID (KEY_EX_ID)
    ) u_cfg (
        .clk             (clk),
        .rst_n           (rst_n),
        .c_s_axis_tdata  (c_s_axis_tdata),
        .c_s_axis_tvalid (c_s_axis_tvalid),
        .c_s_axis_tlast  (c_s_axis_tlast),
        .c_m_axis_tdata  (c_m_axis_tdata),
        .c_m_axis_tvalid (c_m_axis_tvalid),
        .c_m_axis_tlast  (c_m_axis_tlast),
        .off_wr_en       (off_wr_en),
        .mask_wr_en      (mask_wr_en),
        .wr_idx          (wr_idx),
        .off_wr_data     (off_wr_data),
        .mask_wr_data    (mask_wr_data)
    );

endmodule

`default_nettype wire

// File: source/key_table_ram.sv
// per-tenant lookup table with one write port and one registered read port
`default_nettype none

module key_table_ram #(
    parameter type entry_t = logic [7:0]
) (
    input  wire                      clk,
    input  wire                      wr_en,
    input  wire ctrl_pkg::tbl_addr_t wr_idx,
    input  wire entry_t              wr_data,
    input  wire ctrl_pkg::tbl_addr_t rd_idx,
    output entry_t                   rd_data
);

    entry_t mem [ctrl_pkg::TBL_DEPTH];

    // same-address read during a write returns the old entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx];
    end

    // index driven from the control stream must be settled when written
    a_wr_idx_known: assert property (@(posedge clk) wr_en |-> !$isunknown(wr_idx));

endmodule

`default_nettype wire

// File: source/phv_pkg.sv
// PHV container, key and predicate descriptor layout shared by the extractor datapath and testbench
`default_nettype none

package phv_pkg;

    localparam int PHV_W    = 1124;
    localparam int KEY_W    = 197;
    localparam int NUM_CONT = 8;
    localparam int NUM_PRED = 5;
    localparam int PRED_W   = 20;

    typedef logic [PHV_W-1:0] phv_t;
    typedef logic [47:0]      cont6_t;
    typedef logic [31:0]      cont4_t;
    typedef logic [15:0]      cont2_t;

    // 6B slots, 4B slots, 2B slots, then five predicate bits
    typedef logic [KEY_W-1:0] key_t;

    // containers packed from the top, container 7 of each width first
    localparam int CONT6_MSB = PHV_W - 1;
    localparam int CONT4_MSB = CONT6_MSB - NUM_CONT * $bits(cont6_t);
    localparam int CONT2_MSB = CONT4_MSB - NUM_CONT * $bits(cont4_t);

    // descriptors right below the 2B containers, descriptor 0 highest
    localparam int PRED_MSB = CONT2_MSB - NUM_CONT * $bits(cont2_t);

    // tenant table index inside the metadata
    localparam int TENANT_LSB = 133;
    localparam int TENANT_W   = 4;

    typedef enum logic [1:0] {
        OP_GT   = 2'd0,
        OP_GE   = 2'd1,
        OP_EQ   = 2'd2,
        OP_TRUE = 2'd3
    } pred_opc_t;

    typedef enum logic [1:0] {
        WC_2B   = 2'd0,
        WC_4B   = 2'd1,
        WC_6B   = 2'd2,
        WC_NONE = 2'd3
    } wcode_t;

    // container selector inside the operand byte
    localparam int SEL_WC_LSB = 3;
    localparam int SEL_IDX_W  = 3;

    typedef struct packed {
        logic       imm;
        logic [7:0] val;
    } operand_t;

    typedef struct packed {
        pred_opc_t opcode;
        operand_t  a;
        operand_t  b;
    } pred_op_t;

endpackage

`default_nettype wire

// File: source/predicate_unit.sv
// stage predicate comparator, loaded with two operands while the tables are read
`default_nettype none

module predicate_unit (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    op_load,
    input  wire phv_pkg::pred_op_t pred_op,
    input  wire phv_pkg::cont6_t   cont6 [phv_pkg::NUM_CONT],
    input  wire phv_pkg::cont4_t   cont4 [phv_pkg::NUM_CONT],
    input  wire phv_pkg::cont2_t   cont2 [phv_pkg::NUM_CONT],
    output logic                   pred_bit
);

    logic [7:0] opnd_a;
    logic [7:0] opnd_b;

    // immediate, or low byte of the selected container
    function automatic logic [7:0] pick(input phv_pkg::operand_t opnd);
        logic [phv_pkg::SEL_IDX_W-1:0] idx;
        logic [7:0]                    res;
        idx = opnd.val[phv_pkg::SEL_IDX_W-1:0];
        case (phv_pkg::wcode_t'(opnd.val[phv_pkg::SEL_WC_LSB +: 2]))
            phv_pkg::WC_6B: res = cont6[idx][7:0];
            phv_pkg::WC_4B: res = cont4[idx][7:0];
            phv_pkg::WC_2B: res = cont2[idx][7:0];
            default:        res = '0;
        endcase
        return opnd.imm ? opnd.val : res;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opnd_a <= '0;
            opnd_b <= '0;
        end else if (op_load) begin
            opnd_a <= pick(pred_op.a);
            opnd_b <= pick(pred_op.b);
        end
    end

    // unsigned compare
    always_comb begin
        case (pred_op.opcode)
            phv_pkg::OP_GT: pred_bit = opnd_a > opnd_b;
            phv_pkg::OP_GE: pred_bit = opnd_a >= opnd_b;
            phv_pkg::OP_EQ: pred_bit = opnd_a == opnd_b;
            default:        pred_bit = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: sources.f
source/phv_pkg.sv
source/ctrl_pkg.sv
source/key_table_ram.sv
source/predicate_unit.sv
source/key_extract_engine.sv
source/config_writer.sv
source/key_extract_top.sv
verification/key_extract_tb.sv

// File: verification/key_extract_tb.sv
// testbench for the key extractor, applies a table of tenant configs and PHVs against a reference model
`default_nettype none

module key_extract_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          STAGE  = 2;
    localparam int          KEY_EX = 1;
    localparam int          ROWS   = 8;
    localparam logic [31:0] SEED   = 32'h9f04714f;

    logic                 clk;
    logic                 rst_n;
    phv_pkg::phv_t        phv_in;
    logic                 phv_valid_in;
    logic                 ready_in;
    ctrl_pkg::ctrl_data_t c_s_axis_tdata;
    logic                 c_s_axis_tvalid;
    logic                 c_s_axis_tlast;
    logic                 ready_out;
    phv_pkg::phv_t        phv_out;
    logic                 phv_valid_out;
    phv_pkg::key_t        key_out_masked;
    logic                 key_valid_out;
    phv_pkg::key_t        key_mask_out;
    ctrl_pkg::ctrl_data_t c_m_axis_tdata;
    logic                 c_m_axis_tvalid;
    logic                 c_m_axis_tlast;

    // stimulus table, one row per test
    string               name_tab    [ROWS];
    logic [3:0]          tenant_tab  [ROWS];
    bit                  cfg_tab     [ROWS];
    bit                  foreign_tab [ROWS];
    int                  stall_tab   [ROWS];
    phv_pkg::pred_op_t   op_tab      [ROWS];
    ctrl_pkg::key_off_t  off_tab     [ROWS];
    ctrl_pkg::key_mask_t mask_tab    [ROWS];
    phv_pkg::phv_t       phv_tab     [ROWS];
    phv_pkg::key_t       exp_key     [ROWS];

    key_extract_top #(
        .STAGE_ID  (STAGE),
        .KEY_EX_ID (KEY_EX)
    ) i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .phv_in          (phv_in),
        .phv_valid_in    (phv_valid_in),
        .ready_in        (ready_in),
        .c_s_axis_tdata  (c_s_axis_tdata),
        .c_s_axis_tvalid (c_s_axis_tvalid),
        .c_s_axis_tlast  (c_s_axis_tlast),
        .ready_out       (ready_out),
        .phv_out         (phv_out),
        .phv_valid_out   (phv_valid_out),
        .key_out_masked  (key_out_masked),
        .key_valid_out   (key_valid_out),
        .key_mask_out    (key_mask_out),
        .c_m_axis_tdata  (c_m_axis_tdata),
        .c_m_axis_tvalid (c_m_axis_tvalid),
        .c_m_axis_tlast  (c_m_axis_tlast)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_phv(input string name, input phv_pkg::phv_t exp,
                             input phv_pkg::phv_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_key(input string name, input phv_pkg::key_t exp,
                             input phv_pkg::key_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_pkg::ctrl_data_t exp,
                              input ctrl_pkg::ctrl_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic phv_pkg::phv_t rand_wide();
        phv_pkg::phv_t v;
        v = '0;
        for (int i = 0; i < 36; i++) begin
            v = {v[1091:0], $urandom()};
        end
        return v;
    endfunction

    // containers from the top of the PHV, container 7 first
    function automatic phv_pkg::cont6_t cont6_at(input phv_pkg::phv_t p, input int k);
        return p[1123 - (7 - k) * 48 -: 48];
    endfunction

    function automatic phv_pkg::cont4_t cont4_at(input phv_pkg::phv_t p, input int k);
        return p[739 - (7 - k) * 32 -: 32];
    endfunction

    function automatic phv_pkg::cont2_t cont2_at(input phv_pkg::phv_t p, input int k);
        return p[483 - (7 - k) * 16 -: 16];
    endfunction

    function automatic logic [7:0] model_operand(input phv_pkg::phv_t p,
                                                 input phv_pkg::operand_t o);
        phv_pkg::cont6_t c6;
        phv_pkg::cont4_t c4;
        phv_pkg::cont2_t c2;
        c6 = cont6_at(p, o.val[2:0]);
        c4 = cont4_at(p, o.val[2:0]);
        c2 = cont2_at(p, o.val[2:0]);
        if (o.imm) begin
            return o.val;
        end
        case (o.val[4:3])
            2'd2: return c6[7:0];
            2'd1: return c4[7:0];
            2'd0: return c2[7:0];
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic model_pred(input phv_pkg::phv_t p, input phv_pkg::pred_op_t op);
        logic [7:0] a;
        logic [7:0] b;
        logic [1:0] opc;
        a   = model_operand(p, op.a);
        b   = model_operand(p, op.b);
        opc = op.opcode;
        case (opc)
            2'd0: return a > b;
            2'd1: return a >= b;
            2'd2: return a == b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic phv_pkg::key_t model_key(input phv_pkg::phv_t p,
                                                input ctrl_pkg::key_off_t o,
                                                input phv_pkg::pred_op_t op);
        logic [4:0] pf;
        pf = '0;
        pf[4 - STAGE] = model_pred(p, op);
        return {cont6_at(p, o.s6_0), cont6_at(p, o.s6_1),
                cont4_at(p, o.s4_0), cont4_at(p, o.s4_1),
                cont2_at(p, o.s2_0), cont2_at(p, o.s2_1), pf};
    endfunction

    function automatic ctrl_pkg::ctrl_data_t byte_swap(input ctrl_pkg::ctrl_data_t d);
        ctrl_pkg::ctrl_data_t s;
        for (int i = 0; i < 64; i++) begin
            s[8*i +: 8] = d[511 - 8*i -: 8];
        end
        return s;
    endfunction

    function automatic ctrl_pkg::ctrl_data_t header_beat(input int stage, input logic [3:0] sel,
                                                         input logic [7:0] start);
        ctrl_pkg::ctrl_data_t d;
        d = '0;
        d[335:320] = 16'hf2f1;
        d[375:371] = 5'(stage);
        d[370:368] = 3'(KEY_EX);
        d[379:376] = sel;
        d[391:384] = start;
        return d;
    endfunction

    // entry left aligned in the swapped beat
    function automatic ctrl_pkg::ctrl_data_t entry_beat(input logic [196:0] top);
        ctrl_pkg::ctrl_data_t s;
        s = '0;
        s[511:315] = top;
        return byte_swap(s);
    endfunction

    function automatic logic [7:0] cont_sel(input logic [1:0] wc, input logic [2:0] idx);
        return {3'b000, wc, idx};
    endfunction

    function automatic phv_pkg::pred_op_t make_desc(input logic [1:0] opc,
                                                    input logic ai, input logic [7:0] av,
                                                    input logic bi, input logic [7:0] bv);
        phv_pkg::pred_op_t d;
        d.opcode = phv_pkg::pred_opc_t'(opc);
        d.a.imm  = ai;
        d.a.val  = av;
        d.b.imm  = bi;
        d.b.val  = bv;
        return d;
    endfunction

    task automatic add_row(input int i, input string name, input logic [3:0] tenant,
                           input bit cfg, input bit foreign, input int stall,
                           input phv_pkg::pred_op_t op);
        name_tab[i]    = name;
        tenant_tab[i]  = tenant;
        cfg_tab[i]     = cfg;
        foreign_tab[i] = foreign;
        stall_tab[i]   = stall;
        op_tab[i]      = op;
    endtask

    // rows without cfg rely on the second beat written by the row before
    task automatic fill_table();
        phv_pkg::phv_t m1;
        phv_pkg::phv_t m2;
        phv_pkg::phv_t p;
        add_row(0, "gt_imm", 4'd3, 1, 0, 0, make_desc(2'd0, 1, 8'h40, 1, 8'h20));
        add_row(1, "ge_cont6_imm", 4'd4, 0, 0, 0,
                make_desc(2'd1, 0, cont_sel(2'd2, 3'd5), 1, 8'h80));
        add_row(2, "eq_cont4_self", 4'd9, 1, 0, 2,
                make_desc(2'd2, 0, cont_sel(2'd1, 3'd2), 0, cont_sel(2'd1, 3'd2)));
        add_row(3, "gt_cont2_self", 4'd10, 0, 0, 0,
                make_desc(2'd0, 0, cont_sel(2'd0, 3'd7), 0, cont_sel(2'd0, 3'd7)));
        add_row(4, "true_foreign", 4'd0, 1, 1, 1,
                make_desc(2'd3, 0, cont_sel(2'd3, 3'd0), 0, cont_sel(2'd3, 3'd1)));
        add_row(5, "eq_none_imm", 4'd15, 1, 0, 5,
                make_desc(2'd2, 0, cont_sel(2'd3, 3'd4), 1, 8'h00));
        add_row(6, "ge_wrap_idx", 4'd0, 0, 0, 0,
                make_desc(2'd1, 0, cont_sel(2'd0, 3'd1), 0, cont_sel(2'd2, 3'd0)));
        add_row(7, "gt_foreign", 4'd12, 1, 1, 3,
                make_desc(2'd0, 1, 8'h00, 0, cont_sel(2'd1, 3'd7)));
        for (int i = 0; i < ROWS; i++) begin
            off_tab[i] = ctrl_pkg::key_off_t'(18'($urandom()));
            m1 = rand_wide();
            m2 = rand_wide();
            // sparse mask, predicate bits left visible
            mask_tab[i] = m1[196:0] & m2[196:0];
            mask_tab[i][4:0] = '0;
            p = rand_wide();
            p[136:133] = tenant_tab[i];
            p[355 - STAGE * 20 -: 20] = op_tab[i];
            phv_tab[i] = p;
            exp_key[i] = model_key(p, off_tab[i], op_tab[i]) & ~mask_tab[i];
        end
    endtask

    // matching packet, every beat is consumed
    task automatic send_packet(input string name, input ctrl_pkg::ctrl_data_t h,
                               input ctrl_pkg::ctrl_data_t d0, input ctrl_pkg::ctrl_data_t d1);
        ctrl_pkg::ctrl_data_t beats [3];
        beats[0] = h;
        beats[1] = d0;
        beats[2] = d1;
        for (int b = 0; b < 3; b++) begin
            @(posedge clk);
            c_s_axis_tdata  <= beats[b];
            c_s_axis_tvalid <= 1'b1;
            c_s_axis_tlast  <= (b == 2);
            @(negedge clk);
            check_bit({name, " config beat forwarded"}, 1'b0, c_m_axis_tvalid);
        end
        @(posedge clk);
        c_s_axis_tvalid <= 1'b0;
        c_s_axis_tlast  <= 1'b0;
        @(negedge clk);
        check_bit({name, " last config beat forwarded"}, 1'b0, c_m_axis_tvalid);
    endtask

    task automatic send_cfg(input int i);
        int nxt;
        nxt = (i + 1) % ROWS;
        send_packet(name_tab[i], header_beat(STAGE, 4'd0, 8'(tenant_tab[i])),
                    entry_beat({off_tab[i], 179'd0}), entry_beat({off_tab[nxt], 179'd0}));
        send_packet(name_tab[i], header_beat(STAGE, 4'd5, 8'(tenant_tab[i])),
                    entry_beat(mask_tab[i]), entry_beat(mask_tab[nxt]));
    endtask

    // packet for the next stage, would clobber this tenant if taken
    task automatic send_foreign(input int i);
        ctrl_pkg::ctrl_data_t beats [2];
        beats[0] = header_beat(STAGE + 1, 4'd0, 8'(tenant_tab[i]));
        beats[1] = entry_beat({~off_tab[i], 179'd0});
        for (int b = 0; b < 2; b++) begin
            @(posedge clk);
            c_s_axis_tdata  <= beats[b];
            c_s_axis_tvalid <= 1'b1;
            c_s_axis_tlast  <= (b == 1);
            @(posedge clk);
            c_s_axis_tvalid <= 1'b0;
            c_s_axis_tlast  <= 1'b0;
            @(negedge clk);
            check_bit({name_tab[i], " foreign tvalid"}, 1'b1, c_m_axis_tvalid);
            check_ctrl({name_tab[i], " foreign tdata"}, beats[b], c_m_axis_tdata);
            check_bit({name_tab[i], " foreign tlast"}, logic'(b == 1), c_m_axis_tlast);
        end
    endtask

    task automatic run_phv(input int i);
        int edges;
        bit pulse;
        edges = 0;
        pulse = 0;
        @(posedge clk);
        phv_in       <= phv_tab[i];
        phv_valid_in <= 1'b1;
        @(negedge clk);
        check_bit({name_tab[i], " ready_out before accept"}, 1'b1, ready_out);
        // accepting edge
        @(posedge clk);
        phv_valid_in <= 1'b0;
        @(negedge clk);
        check_bit({name_tab[i], " ready_out after accept"}, 1'b0, ready_out);
        while (!pulse) begin
            @(posedge clk);
            edges++;
            // ready_in low for stall cycles before the emit edge
            if (edges == 2 + stall_tab[i]) begin
                ready_in <= 1'b1;
            end else if (edges == 2) begin
                ready_in <= 1'b0;
            end
            @(negedge clk);
            pulse = (edges == 3 + stall_tab[i]);
            check_bit({name_tab[i], " phv_valid_out"}, pulse, phv_valid_out);
            check_bit({name_tab[i], " key_valid_out"}, pulse, key_valid_out);
            check_bit({name_tab[i], " ready_out"}, pulse, ready_out);
        end
        check_phv({name_tab[i], " phv_out"}, phv_tab[i], phv_out);
        check_key({name_tab[i], " key_out_masked"}, exp_key[i], key_out_masked);
        check_key({name_tab[i], " key_mask_out"}, mask_tab[i], key_mask_out);
        @(posedge clk);
        @(negedge clk);
        check_bit({name_tab[i], " single phv pulse"}, 1'b0, phv_valid_out);
        check_bit({name_tab[i], " single key pulse"}, 1'b0, key_valid_out);
        check_key({name_tab[i], " key held"}, exp_key[i], key_out_masked);
    endtask

    initial begin
        longint limit;
        clk             = 1'b0;
        rst_n           = 1'b0;
        phv_in          = '0;
        phv_valid_in    = 1'b0;
        ready_in        = 1'b1;
        c_s_axis_tdata  = '0;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        void'($urandom(SEED));
        fill_table();
        // reset and margin, then one budget per row
        limit = 15 * 40;
        for (int i = 0; i < ROWS; i++) begin
            limit += (stall_tab[i] + 40) * 40;
        end
        fork
            begin
                #(limit);
                $display("Timeout: no end of run after %0d ns", limit);
                $display("Something failed");
                $fatal(1, "watchdog expired");
            end
        join_none
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("reset ready_out", 1'b1, ready_out);
        check_bit("reset phv_valid_out", 1'b0, phv_valid_out);
        check_bit("reset key_valid_out", 1'b0, key_valid_out);
        check_bit("reset c_m_axis_tvalid", 1'b0, c_m_axis_tvalid);
        for (int i = 0; i < ROWS; i++) begin
            if (cfg_tab[i]) begin
                send_cfg(i);
            end
            if (foreign_tab[i]) begin
                send_foreign(i);
            end
            run_phv(i);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire
